//--- Makefile
TOP = tb_cpu

sim:
	verilator --binary -j 0 --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- build.f
verilog/cpu_pkg.sv
verilog/data_bank.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/cpu_top.sv
tb/tb_cpu.sv

//--- tb/tb_cpu.sv
`default_nettype none

module tb_cpu;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMEM_DEPTH = 32;
	localparam int DMEM_WORDS = 16;
	localparam int DMEM_BYTES = 4 * DMEM_WORDS;
	localparam int ADDR_W = $clog2(IMEM_DEPTH);
	localparam int NUM_PROGRAMS = 40;
	localparam int CYCLE_LIMIT = NUM_PROGRAMS * (IMEM_DEPTH * 5 + 40);

	localparam logic [1:0] CL_ALU = 2'b01;
	localparam logic [1:0] CL_MEM = 2'b10;
	localparam logic [2:0] OP_ADD = 3'b001;
	localparam logic [2:0] OP_INC = 3'b011;
	localparam logic [2:0] OP_MOVE = 3'b111;
	localparam logic [2:0] OP_MOVE_LO = 3'b101;
	localparam logic [2:0] OP_MOVE_HI = 3'b110;
	localparam logic [2:0] OP_LOAD_LO = 3'b001;
	localparam logic [2:0] OP_LOAD_HI = 3'b010;

	logic clk;
	logic resetn;
	logic load_valid;
	logic [ADDR_W-1:0] load_addr;
	logic [31:0] load_instr;
	logic start;
	logic halted;
	logic wb_valid;
	logic [2:0] wb_reg;
	logic [1:0] wb_lanes;
	logic [31:0] wb_data;

	logic [31:0] lfsr;
	logic [31:0] prog [IMEM_DEPTH];
	int prog_len;
	int prog_num;
	logic [31:0] model_regs [8];
	logic [7:0] model_mem [DMEM_BYTES];  // byte a+i of a word sits in bits 31-8i
	logic [2:0] exp_reg_q [$];
	logic [1:0] exp_lanes_q [$];
	logic [31:0] exp_data_q [$];
	int expected_count;
	int commit_count;
	int cycle_count;

	cpu_top #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_WORDS(DMEM_WORDS)) DUT (
		.clk(clk), .resetn(resetn), .load_valid(load_valid), .load_addr(load_addr),
		.load_instr(load_instr), .start(start), .halted(halted), .wb_valid(wb_valid),
		.wb_reg(wb_reg), .wb_lanes(wb_lanes), .wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] half_mask(logic [1:0] lanes);
		return {{16{lanes[1]}}, {16{lanes[0]}}};
	endfunction

	task automatic fail_and_stop();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			fail_and_stop();
		end
	endtask

	task automatic gen_program();
		logic [31:0] v, kind, op, rs1, rs2, imm, immf;
		logic [1:0] cls;
		int reg_bits;
		rand_bits(1, v);
		reg_bits = v[0] ? 2 : 3;  // fewer registers, denser dependencies
		rand_bits(5, v);
		prog_len = 1 + int'(v % (IMEM_DEPTH - 1));
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			prog[i] = '0;  // nop padding, last word always nop
			if (i < prog_len) begin
				rand_bits(3, kind);
				rand_bits(3, op);
				rand_bits(1, immf);
				rand_bits(reg_bits, rs1);
				rand_bits(reg_bits, rs2);
				rand_bits(16, imm);
				if (kind == 0) begin
					rand_bits(1, v);
					cls = v[0] ? 2'b11 : 2'b00;  // audio or plain nop
				end else if (kind < 5) begin
					cls = CL_ALU;
				end else begin
					cls = CL_MEM;
				end
				prog[i] = {immf[0], cls, op[2:0], 4'b0000, rs1[2:0], rs2[2:0], imm[15:0]};
			end
		end
	endtask

	task automatic commit_expected(input logic [2:0] rd, input logic [1:0] lanes,
		input logic [31:0] data);
		model_regs[rd] = (model_regs[rd] & ~half_mask(lanes)) | (data & half_mask(lanes));
		exp_reg_q.push_back(rd);
		exp_lanes_q.push_back(lanes);
		exp_data_q.push_back(data & half_mask(lanes));
		expected_count++;
	endtask

	// sequential execution of the program
	task automatic run_model();
		logic [31:0] ins, op1, op2, word;
		logic [2:0] op, rs1, rs2;
		logic [1:0] cls;
		int addr;
		for (int r = 0; r < 8; r++)
			model_regs[r] = '0;
		for (int b = 0; b < DMEM_BYTES; b++)
			model_mem[b] = '0;
		exp_reg_q.delete();
		exp_lanes_q.delete();
		exp_data_q.delete();
		expected_count = 0;
		for (int i = 0; i < prog_len; i++) begin
			ins = prog[i];
			cls = ins[30:29];
			op = ins[28:26];
			rs1 = ins[21:19];  // also the destination
			rs2 = ins[18:16];
			op1 = model_regs[rs1];
			if (!ins[31])
				op2 = model_regs[rs2];
			else if (cls == CL_ALU && op == OP_MOVE_HI)
				op2 = {ins[15:0], 16'h0000};
			else
				op2 = {16'h0000, ins[15:0]};
			if (cls == CL_ALU) begin
				case (op)
					OP_ADD:     commit_expected(rs1, 2'b11, op1 + op2);
					OP_INC:     commit_expected(rs1, 2'b11, op1 + 32'd1);
					OP_MOVE:    commit_expected(rs1, 2'b11, op2);
					OP_MOVE_LO: commit_expected(rs1, 2'b01, op2);
					OP_MOVE_HI: commit_expected(rs1, 2'b10, op2);
					default:    commit_expected(rs1, 2'b11, 32'h0);
				endcase
			end else if (cls == CL_MEM) begin
				addr = int'(op2 % DMEM_BYTES);
				for (int k = 0; k < 4; k++)
					word[31 - 8*k -: 8] = model_mem[(addr + k) % DMEM_BYTES];
				if (op[2]) begin
					// op bit 1 for bytes a, a+1 and bit 0 for a+2, a+3
					for (int k = 0; k < 4; k++) begin
						if ((k < 2) ? op[1] : op[0])
							model_mem[(addr + k) % DMEM_BYTES] = op1[31 - 8*k -: 8];
					end
				end else if (op == OP_LOAD_LO) begin
					commit_expected(rs1, 2'b01, word);
				end else if (op == OP_LOAD_HI) begin
					commit_expected(rs1, 2'b10, word);
				end
			end
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		resetn <= 1'b0;
		load_valid <= 1'b0;
		start <= 1'b0;
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
	endtask

	task automatic check_reset_outputs();
		string tag;
		@(negedge clk);
		tag = $sformatf("program %0d after reset", prog_num);
		check_value({tag, " halted"}, 32'h0, 32'(halted));
		check_value({tag, " wb_valid"}, 32'h0, 32'(wb_valid));
		check_value({tag, " wb_reg"}, 32'h0, 32'(wb_reg));
		check_value({tag, " wb_lanes"}, 32'h0, 32'(wb_lanes));
		check_value({tag, " wb_data"}, 32'h0, wb_data);
	endtask

	task automatic load_program();
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			@(posedge clk);
			load_valid <= 1'b1;
			load_addr <= ADDR_W'(i);
			load_instr <= prog[i];
		end
		@(posedge clk);
		load_valid <= 1'b0;
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: programs still running after %0d cycles", CYCLE_LIMIT);
			fail_and_stop();
		end
	end

	// commits compared in program order
	always @(negedge clk) begin : commit_monitor
		logic [2:0] rd;
		logic [1:0] lanes;
		logic [31:0] data;
		string tag;
		if (wb_valid) begin
			if (exp_reg_q.size() == 0) begin
				$display("program %0d made a commit that the model does not expect",
					prog_num);
				fail_and_stop();
			end else begin
				rd = exp_reg_q.pop_front();
				lanes = exp_lanes_q.pop_front();
				data = exp_data_q.pop_front();
				tag = $sformatf("program %0d commit %0d", prog_num, commit_count);
				check_value({tag, " wb_reg"}, 32'(rd), 32'(wb_reg));
				check_value({tag, " wb_lanes"}, 32'(lanes), 32'(wb_lanes));
				check_value({tag, " wb_data"}, data, wb_data & half_mask(lanes));
				commit_count++;
			end
		end
	end

	initial begin
		resetn = 1'b0;
		load_valid = 1'b0;
		load_addr = '0;
		load_instr = '0;
		start = 1'b0;
		lfsr = 32'hb0c3;
		cycle_count = 0;
		commit_count = 0;
		expected_count = 0;
		prog_num = 0;
		for (int p = 0; p < NUM_PROGRAMS; p++) begin
			prog_num = p;
			gen_program();
			run_model();
			apply_reset();
			commit_count = 0;
			check_reset_outputs();
			load_program();
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			while (!halted)
				@(negedge clk);
			repeat (8) @(posedge clk);  // drain takes at most 4
			check_value($sformatf("program %0d commit count", p), 32'(expected_count),
				32'(commit_count));
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;
	typedef logic [31:0] instr_t;
	typedef logic [2:0]  reg_idx_t;
	typedef logic [1:0]  lane_t;     // [1] upper half, [0] lower half
	typedef logic [3:0]  byte_en_t;  // [3] is byte a, the most significant
	typedef logic [2:0]  op_t;

	// audio class is kept in the encoding but does nothing
	typedef enum logic [1:0] {
		CLASS_NOP,
		CLASS_ALU,
		CLASS_MEM,
		CLASS_AUDIO
	} class_e;

	typedef enum logic [1:0] {
		WB_NONE,
		WB_ALU,
		WB_MEM,
		WB_MOVE
	} wb_sel_e;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_RUN,
		FETCH_HALT
	} fetch_state_e;

	// alu class
	localparam op_t OP_ADD     = 3'b001;
	localparam op_t OP_INC     = 3'b011;
	localparam op_t OP_MOVE    = 3'b111;
	localparam op_t OP_MOVE_LO = 3'b101;
	localparam op_t OP_MOVE_HI = 3'b110;

	// memory class
	localparam op_t OP_LOAD_LO = 3'b001;
	localparam op_t OP_LOAD_HI = 3'b010;
	localparam int  STORE_BIT  = 2;

	// instruction fields
	localparam int IMM_BIT   = 31;
	localparam int CLASS_LSB = 29;  // 2 bits
	localparam int OP_LSB    = 26;  // 3 bits
	localparam int RS1_LSB   = 19;  // also the destination
	localparam int RS2_LSB   = 16;
	localparam int IMM_LSB   = 0;   // 16 bits

endpackage

`default_nettype wire

//--- verilog/cpu_top.sv
`default_nettype none

module cpu_top #(
	parameter int IMEM_DEPTH = 32,
	parameter int DMEM_WORDS = 16
) (
	input  wire                            clk,
	input  wire                            resetn,
	input  wire                            load_valid,
	input  wire [$clog2(IMEM_DEPTH)-1:0]   load_addr,
	input  wire cpu_pkg::instr_t           load_instr,
	input  wire                            start,
	output logic                           halted,
	output logic                           wb_valid,
	output cpu_pkg::reg_idx_t              wb_reg,
	output cpu_pkg::lane_t                 wb_lanes,
	output cpu_pkg::word_t                 wb_data
);

	logic stall;
	cpu_pkg::instr_t if_id_instr;

	// register file read side
	cpu_pkg::reg_idx_t rs1_idx, rs2_idx;
	cpu_pkg::word_t rs1_val, rs2_val;

	// ID/EX
	cpu_pkg::op_t ex_alu_op;
	cpu_pkg::word_t ex_op1, ex_op2;
	logic ex_store, ex_load;
	cpu_pkg::byte_en_t ex_byte_en;
	cpu_pkg::lane_t ex_lanes;
	cpu_pkg::reg_idx_t ex_rd;
	cpu_pkg::wb_sel_e ex_wb_sel;

	// EX/MEM
	cpu_pkg::word_t mem_result, mem_op2, mem_store_data;
	logic mem_store, mem_load;
	cpu_pkg::byte_en_t mem_byte_en;
	cpu_pkg::lane_t mem_lanes;
	cpu_pkg::reg_idx_t mem_rd;
	cpu_pkg::wb_sel_e mem_wb_sel;

	cpu_pkg::reg_idx_t wb_rd;  // same register as wb_reg, for hazard checks

	fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
		.clk(clk), .resetn(resetn), .stall(stall), .start(start),
		.load_valid(load_valid), .load_addr(load_addr), .load_instr(load_instr),
		.if_id_instr(if_id_instr), .halted(halted)
	);

	decode_stage u_decode (
		.clk(clk), .resetn(resetn), .stall(stall), .if_id_instr(if_id_instr),
		.rs1_val(rs1_val), .rs2_val(rs2_val), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.ex_alu_op(ex_alu_op), .ex_op1(ex_op1), .ex_op2(ex_op2), .ex_store(ex_store),
		.ex_byte_en(ex_byte_en), .ex_load(ex_load), .ex_lanes(ex_lanes),
		.ex_rd(ex_rd), .ex_wb_sel(ex_wb_sel)
	);

	hazard_unit u_hazard (
		.id_instr(if_id_instr),
		.ex_rd(ex_rd), .ex_lanes(ex_lanes),
		.mem_rd(mem_rd), .mem_lanes(mem_lanes),
		.wb_rd(wb_rd), .wb_lanes(wb_lanes),
		.stall(stall)
	);

	execute_stage u_execute (
		.clk(clk), .resetn(resetn), .ex_alu_op(ex_alu_op), .ex_op1(ex_op1),
		.ex_op2(ex_op2), .ex_store(ex_store), .ex_byte_en(ex_byte_en),
		.ex_load(ex_load), .ex_lanes(ex_lanes), .ex_rd(ex_rd), .ex_wb_sel(ex_wb_sel),
		.mem_result(mem_result), .mem_op2(mem_op2), .mem_store_data(mem_store_data),
		.mem_store(mem_store), .mem_byte_en(mem_byte_en), .mem_load(mem_load),
		.mem_lanes(mem_lanes), .mem_rd(mem_rd), .mem_wb_sel(mem_wb_sel)
	);

	mem_wb_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem_wb (
		.clk(clk), .resetn(resetn), .mem_result(mem_result), .mem_op2(mem_op2),
		.mem_store_data(mem_store_data), .mem_store(mem_store),
		.mem_byte_en(mem_byte_en), .mem_load(mem_load), .mem_lanes(mem_lanes),
		.mem_rd(mem_rd), .mem_wb_sel(mem_wb_sel),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_lanes(wb_lanes),
		.wb_data(wb_data), .wb_rd(wb_rd)
	);

	reg_file u_reg_file (
		.clk(clk), .resetn(resetn), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.we_lanes(wb_lanes), .wr_idx(wb_reg), .wr_data(wb_data),
		.rs1_val(rs1_val), .rs2_val(rs2_val)
	);

endmodule

`default_nettype wire

//--- verilog/data_bank.sv
`default_nettype none

module data_bank #(
	parameter int DMEM_WORDS = 16
) (
	input  wire                          clk,
	input  wire                          resetn,
	input  wire                          we,
	input  wire [$clog2(DMEM_WORDS)-1:0] addr,
	input  wire [7:0]                    din,
	output logic [7:0]                   dout
);

	logic [7:0] mem [DMEM_WORDS];

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= 8'h00;
			dout <= 8'h00;
		end else begin
			if (we)
				mem[addr] <= din;
			dout <= mem[addr];  // old contents on a same-cycle write
		end
	end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none

module decode_stage (
	input  wire                        clk,
	input  wire                        resetn,
	input  wire                        stall,
	input  wire cpu_pkg::instr_t       if_id_instr,
	input  wire cpu_pkg::word_t        rs1_val,
	input  wire cpu_pkg::word_t        rs2_val,
	output cpu_pkg::reg_idx_t          rs1_idx,
	output cpu_pkg::reg_idx_t          rs2_idx,
	output cpu_pkg::op_t               ex_alu_op,
	output cpu_pkg::word_t             ex_op1,
	output cpu_pkg::word_t             ex_op2,
	output logic                       ex_store,
	output cpu_pkg::byte_en_t          ex_byte_en,
	output logic                       ex_load,
	output cpu_pkg::lane_t             ex_lanes,
	output cpu_pkg::reg_idx_t          ex_rd,
	output cpu_pkg::wb_sel_e           ex_wb_sel
);

	cpu_pkg::class_e cls;
	cpu_pkg::op_t op;
	cpu_pkg::half_t imm_val;
	logic imm_flag;
	logic is_alu, is_move, is_mem, is_store, is_load, bubble;
	cpu_pkg::word_t op2;
	cpu_pkg::lane_t lanes;
	cpu_pkg::byte_en_t byte_en;
	cpu_pkg::wb_sel_e wb_sel;

	assign imm_flag = if_id_instr[cpu_pkg::IMM_BIT];
	assign cls = cpu_pkg::class_e'(if_id_instr[cpu_pkg::CLASS_LSB +: 2]);
	assign op = if_id_instr[cpu_pkg::OP_LSB +: 3];
	assign rs1_idx = if_id_instr[cpu_pkg::RS1_LSB +: 3];
	assign rs2_idx = if_id_instr[cpu_pkg::RS2_LSB +: 3];
	assign imm_val = if_id_instr[cpu_pkg::IMM_LSB +: 16];

	assign is_alu = (cls == cpu_pkg::CLASS_ALU);
	assign is_move = is_alu && (op == cpu_pkg::OP_MOVE || op == cpu_pkg::OP_MOVE_LO ||
		op == cpu_pkg::OP_MOVE_HI);
	assign is_mem = (cls == cpu_pkg::CLASS_MEM);
	assign is_store = is_mem && op[cpu_pkg::STORE_BIT];
	assign is_load = is_mem && (op == cpu_pkg::OP_LOAD_LO || op == cpu_pkg::OP_LOAD_HI);
	assign bubble = stall || !(is_alu || is_mem);  // audio falls in here too

	always_comb begin
		if (!imm_flag)
			op2 = rs2_val;
		else if (is_move && op == cpu_pkg::OP_MOVE_HI)
			op2 = {imm_val, 16'h0000};  // immediate lands in the upper half
		else
			op2 = {16'h0000, imm_val};
	end

	always_comb begin
		lanes = 2'b00;
		if (is_alu) begin
			if (op == cpu_pkg::OP_MOVE_LO)
				lanes = 2'b01;
			else if (op == cpu_pkg::OP_MOVE_HI)
				lanes = 2'b10;
			else
				lanes = 2'b11;
		end else if (is_load) begin
			lanes = (op == cpu_pkg::OP_LOAD_LO) ? 2'b01 : 2'b10;
		end
	end

	// op[1] covers bytes a,a+1 and op[0] bytes a+2,a+3
	assign byte_en = is_store ? {op[1], op[1], op[0], op[0]} : 4'b0000;

	assign wb_sel = is_move ? cpu_pkg::WB_MOVE :
		is_alu ? cpu_pkg::WB_ALU :
		is_load ? cpu_pkg::WB_MEM : cpu_pkg::WB_NONE;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			ex_alu_op <= '0;
			ex_op1 <= '0;
			ex_op2 <= '0;
			ex_store <= 1'b0;
			ex_byte_en <= '0;
			ex_load <= 1'b0;
			ex_lanes <= '0;
			ex_rd <= '0;
			ex_wb_sel <= cpu_pkg::WB_NONE;
		end else if (bubble) begin
			ex_alu_op <= '0;
			ex_op1 <= '0;
			ex_op2 <= '0;
			ex_store <= 1'b0;
			ex_byte_en <= '0;
			ex_load <= 1'b0;
			ex_lanes <= '0;
			ex_rd <= '0;
			ex_wb_sel <= cpu_pkg::WB_NONE;
		end else begin
			ex_alu_op <= (is_alu && !is_move) ? op : 3'b000;
			ex_op1 <= rs1_val;
			ex_op2 <= op2;
			ex_store <= is_store;
			ex_byte_en <= byte_en;
			ex_load <= is_load;
			ex_lanes <= lanes;
			ex_rd <= rs1_idx;  // rs1 doubles as destination
			ex_wb_sel <= wb_sel;
		end
	end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

module execute_stage (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire cpu_pkg::op_t      ex_alu_op,
	input  wire cpu_pkg::word_t    ex_op1,
	input  wire cpu_pkg::word_t    ex_op2,
	input  wire                    ex_store,
	input  wire cpu_pkg::byte_en_t ex_byte_en,
	input  wire                    ex_load,
	input  wire cpu_pkg::lane_t    ex_lanes,
	input  wire cpu_pkg::reg_idx_t ex_rd,
	input  wire cpu_pkg::wb_sel_e  ex_wb_sel,
	output cpu_pkg::word_t         mem_result,
	output cpu_pkg::word_t         mem_op2,
	output cpu_pkg::word_t         mem_store_data,
	output logic                   mem_store,
	output cpu_pkg::byte_en_t      mem_byte_en,
	output logic                   mem_load,
	output cpu_pkg::lane_t         mem_lanes,
	output cpu_pkg::reg_idx_t      mem_rd,
	output cpu_pkg::wb_sel_e       mem_wb_sel
);

	cpu_pkg::word_t alu_result;

	always_comb begin
		case (ex_alu_op)
			cpu_pkg::OP_ADD: alu_result = ex_op1 + ex_op2;
			cpu_pkg::OP_INC: alu_result = ex_op1 + 32'd1;
			default:         alu_result = '0;  // unused alu codes give zero
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			mem_result <= '0;
			mem_op2 <= '0;
			mem_store_data <= '0;
			mem_store <= 1'b0;
			mem_byte_en <= '0;
			mem_load <= 1'b0;
			mem_lanes <= '0;
			mem_rd <= '0;
			mem_wb_sel <= cpu_pkg::WB_NONE;
		end else begin
			mem_result <= alu_result;
			mem_op2 <= ex_op2;          // address or move data
			mem_store_data <= ex_op1;
			mem_store <= ex_store;
			mem_byte_en <= ex_byte_en;
			mem_load <= ex_load;
			mem_lanes <= ex_lanes;
			mem_rd <= ex_rd;
			mem_wb_sel <= ex_wb_sel;
		end
	end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`default_nettype none

module fetch_stage #(
	parameter int IMEM_DEPTH = 32
) (
	input  wire                          clk,
	input  wire                          resetn,
	input  wire                          stall,
	input  wire                          start,
	input  wire                          load_valid,
	input  wire [$clog2(IMEM_DEPTH)-1:0] load_addr,
	input  wire cpu_pkg::instr_t         load_instr,
	output cpu_pkg::instr_t              if_id_instr,
	output logic                         halted
);

	localparam int PC_W = $clog2(IMEM_DEPTH);
	localparam logic [PC_W-1:0] PC_LAST = PC_W'(IMEM_DEPTH - 1);

	cpu_pkg::instr_t imem [IMEM_DEPTH];
	logic [PC_W-1:0] pc;
	cpu_pkg::fetch_state_e state;
	logic issue;

	assign halted = (state == cpu_pkg::FETCH_HALT);
	// start issues address 0 in the same cycle it leaves idle
	assign issue = (state != cpu_pkg::FETCH_IDLE || start) && !stall;

	// program load only while idle
	always_ff @(posedge clk) begin
		if (load_valid && state == cpu_pkg::FETCH_IDLE)
			imem[load_addr] <= load_instr;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= cpu_pkg::FETCH_IDLE;
			pc <= '0;
			if_id_instr <= '0;
		end else if (issue) begin
			if_id_instr <= imem[pc];
			if (pc == PC_LAST) begin
				state <= cpu_pkg::FETCH_HALT;  // pc saturates and the last word is reissued
			end else begin
				pc <= pc + 1'b1;
				state <= cpu_pkg::FETCH_RUN;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
`default_nettype none

module hazard_unit (
	input  wire cpu_pkg::instr_t   id_instr,
	input  wire cpu_pkg::reg_idx_t ex_rd,
	input  wire cpu_pkg::lane_t    ex_lanes,
	input  wire cpu_pkg::reg_idx_t mem_rd,
	input  wire cpu_pkg::lane_t    mem_lanes,
	input  wire cpu_pkg::reg_idx_t wb_rd,
	input  wire cpu_pkg::lane_t    wb_lanes,
	output logic                   stall
);

	cpu_pkg::class_e cls;
	cpu_pkg::op_t op;
	cpu_pkg::reg_idx_t rs1, rs2;
	logic id_live, use_rs2;

	// a stage only counts when it will actually write a register
	function automatic logic hit(cpu_pkg::reg_idx_t src, cpu_pkg::reg_idx_t rd,
		cpu_pkg::lane_t lanes);
		return (lanes != 2'b00) && (rd == src);
	endfunction

	assign cls = cpu_pkg::class_e'(id_instr[cpu_pkg::CLASS_LSB +: 2]);
	assign op = id_instr[cpu_pkg::OP_LSB +: 3];
	assign rs1 = id_instr[cpu_pkg::RS1_LSB +: 3];
	assign rs2 = id_instr[cpu_pkg::RS2_LSB +: 3];

	assign id_live = (cls == cpu_pkg::CLASS_ALU) || (cls == cpu_pkg::CLASS_MEM);
	assign use_rs2 = (op != cpu_pkg::OP_INC) && !id_instr[cpu_pkg::IMM_BIT];

	assign stall = id_live && (
		hit(rs1, ex_rd, ex_lanes) || hit(rs1, mem_rd, mem_lanes) ||
		hit(rs1, wb_rd, wb_lanes) ||
		(use_rs2 && (hit(rs2, ex_rd, ex_lanes) || hit(rs2, mem_rd, mem_lanes) ||
		hit(rs2, wb_rd, wb_lanes))));

endmodule

`default_nettype wire

//--- verilog/mem_wb_stage.sv
`default_nettype none

module mem_wb_stage #(
	parameter int DMEM_WORDS = 16
) (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire cpu_pkg::word_t    mem_result,
	input  wire cpu_pkg::word_t    mem_op2,
	input  wire cpu_pkg::word_t    mem_store_data,
	input  wire                    mem_store,
	input  wire cpu_pkg::byte_en_t mem_byte_en,
	input  wire                    mem_load,
	input  wire cpu_pkg::lane_t    mem_lanes,
	input  wire cpu_pkg::reg_idx_t mem_rd,
	input  wire cpu_pkg::wb_sel_e  mem_wb_sel,
	output logic                   wb_valid,
	output cpu_pkg::reg_idx_t      wb_reg,
	output cpu_pkg::lane_t         wb_lanes,
	output cpu_pkg::word_t         wb_data,
	output cpu_pkg::reg_idx_t      wb_rd
);

	localparam int AW = $clog2(DMEM_WORDS);

	logic [1:0] off, rd_off;
	logic [AW-1:0] base;
	logic [3:0][7:0] st_bytes;  // [3] is byte a
	logic [7:0] bank_q [4];
	cpu_pkg::word_t ld_word, result_q, op2_q;
	cpu_pkg::wb_sel_e sel_q;

	assign off = mem_op2[1:0];
	assign base = mem_op2[2 +: AW];  // word index wraps with the bank depth
	assign st_bytes = mem_store_data;

	// bank b holds byte addresses 4k+b
	for (genvar b = 0; b < 4; b++) begin : g_bank
		logic [1:0] idx;  // which byte of the word lands in this bank
		logic [AW-1:0] addr;

		assign idx = 2'(b) - off;
		assign addr = (2'(b) < off) ? base + 1'b1 : base;

		data_bank #(.DMEM_WORDS(DMEM_WORDS)) u_bank (
			.clk(clk), .resetn(resetn),
			.we(mem_store && mem_byte_en[~idx]),
			.addr(addr), .din(st_bytes[~idx]), .dout(bank_q[b])
		);
	end

	// undo the rotation with the offset of the load
	always_comb begin
		logic [1:0] sel;
		for (int i = 0; i < 4; i++) begin
			sel = rd_off + 2'(i);
			ld_word[31 - 8*i -: 8] = bank_q[sel];
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			rd_off <= '0;
			result_q <= '0;
			op2_q <= '0;
			sel_q <= cpu_pkg::WB_NONE;
			wb_reg <= '0;
			wb_lanes <= '0;
		end else begin
			if (mem_load)
				rd_off <= off;
			result_q <= mem_result;
			op2_q <= mem_op2;
			sel_q <= mem_wb_sel;
			wb_reg <= mem_rd;
			wb_lanes <= mem_lanes;
		end
	end

	always_comb begin
		case (sel_q)
			cpu_pkg::WB_ALU:  wb_data = result_q;
			cpu_pkg::WB_MEM:  wb_data = ld_word;
			cpu_pkg::WB_MOVE: wb_data = op2_q;
			default:          wb_data = '0;
		endcase
	end

	assign wb_valid = (wb_lanes != 2'b00);
	assign wb_rd = wb_reg;

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none

module reg_file (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire cpu_pkg::reg_idx_t rs1_idx,
	input  wire cpu_pkg::reg_idx_t rs2_idx,
	input  wire cpu_pkg::lane_t    we_lanes,
	input  wire cpu_pkg::reg_idx_t wr_idx,
	input  wire cpu_pkg::word_t    wr_data,
	output cpu_pkg::word_t         rs1_val,
	output cpu_pkg::word_t         rs2_val
);

	cpu_pkg::word_t regs [8];

	// reads are combinational, no bypass from the write port
	assign rs1_val = regs[rs1_idx];
	assign rs2_val = regs[rs2_idx];

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else begin
			if (we_lanes[0])
				regs[wr_idx][15:0] <= wr_data[15:0];
			if (we_lanes[1])
				regs[wr_idx][31:16] <= wr_data[31:16];
		end
	end

endmodule

`default_nettype wire
